/* build.f */
logic/osf_pkg.sv
logic/osf_param_latch.sv
logic/osf_accumulator.sv
logic/oversample_filter.sv
logic/osf_output_arbiter.sv
logic/osf_top.sv
test/osf_checker.sv
test/osf_tb.sv

/* logic/osf_accumulator.sv */
`timescale 1ns/100ps
`default_nettype none

// wide signed sum with arithmetic shift down to the mean
module osf_accumulator
	import osf_pkg::*;
#(
	parameter int W_IN  = W_IN_DEF,	// sample width
	parameter int W_OUT = W_OUT_DEF,	// mean width
	parameter int W_OS  = W_OS_DEF	// log2 ratio width
)(
	input  wire                     clk_in,
	input  wire                     reset_in,

	// control from the filter fsm
	input  wire                     clear,	// zero the sum
	input  wire                     add,	// fold in sample

	input  wire signed [W_IN-1:0]   sample,
	input  wire [W_OS-1:0]          os_cur,	// shift amount

	output logic signed [W_OUT-1:0] mean	// floor of sum / 2^os
);

	////////////////////////////////////////
	// sizing
	////////////////////////////////////////
	// headroom for 2^max_os full scale samples
	localparam int MAX_OS = max_os(W_OS);
	localparam int W_SUM  = W_IN + MAX_OS;

	logic signed [W_SUM-1:0] sum;
	logic signed [W_SUM-1:0] sample_ext;	// sign extended input
	logic signed [W_SUM-1:0] shifted;

	assign sample_ext = {{(W_SUM-W_IN){sample[W_IN-1]}}, sample};

	////////////////////////////////////////
	// sum register
	////////////////////////////////////////
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			sum <= '0;
		end else if (clear) begin
			sum <= '0;	// idle, settling or deactivated
		end else if (add) begin
			sum <= sum + sample_ext;
		end
	end

	// arithmetic shift keeps the sign, so this rounds toward minus infinity
	assign shifted = sum >>> os_cur;

	// drop the headroom bits, the mean fits W_IN again
	assign mean = W_OUT'(shifted);

endmodule

`default_nettype wire

/* logic/osf_output_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

// merges per-channel results into one tagged stream, round robin
module osf_output_arbiter
	import osf_pkg::*;
#(
	parameter int N_CH  = N_CH_DEF,
	parameter int W_OUT = W_OUT_DEF
)(
	input  wire                        clk_in,
	input  wire                        reset_in,

	// from the filters
	input  wire signed [W_OUT-1:0]     result [N_CH],
	input  wire [N_CH-1:0]             result_valid,

	// tagged stream out, no back-pressure
	output logic signed [W_OUT-1:0]    data_out,
	output logic [w_chan(N_CH)-1:0]    chan_out,
	output logic                       data_valid_out	// one pulse per result
);

	localparam int W_CH = w_chan(N_CH);

	logic [N_CH-1:0]         pending;	// result waiting
	logic signed [W_OUT-1:0] captured [N_CH];
	logic [N_CH-1:0]         req;	// pending or arriving now
	logic [W_CH-1:0]         last;	// last channel served
	logic [W_CH-1:0]         grant_idx;
	logic                    found;

	// a fresh result can go out in its own SEND cycle
	assign req = pending | result_valid;

	////////////////////////////////////////
	// round robin pick
	////////////////////////////////////////
	always_comb begin
		int idx;
		found     = 1'b0;
		grant_idx = last;
		idx       = 0;
		// start one past last, wrap at N_CH
		for (int k = 1; k <= N_CH; k++) begin
			idx = int'(last) + k;
			if (idx >= N_CH) idx = idx - N_CH;
			if (!found && req[idx]) begin
				found     = 1'b1;
				grant_idx = W_CH'(idx);
			end
		end
	end

	////////////////////////////////////////
	// control regs
	////////////////////////////////////////
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			pending        <= '0;
			last           <= W_CH'(N_CH - 1);	// channel 0 first
			data_valid_out <= 1'b0;
		end else begin
			for (int i = 0; i < N_CH; i++) begin
				pending[i] <= req[i] && !(found && (grant_idx == W_CH'(i)));
			end
			if (found) last <= grant_idx;
			data_valid_out <= found;
		end
	end

	// payload
	always_ff @(posedge clk_in) begin
		for (int i = 0; i < N_CH; i++) begin
			if (result_valid[i]) captured[i] <= result[i];
		end
		if (found) begin
			// bypass the capture reg when it is loading this cycle
			data_out <= result_valid[grant_idx] ? result[grant_idx] : captured[grant_idx];
			chan_out <= grant_idx;
		end
	end

	// a channel must be drained before its next result lands
	for (genvar i = 0; i < N_CH; i++) begin : g_chk
		a_no_overrun: assert property (@(posedge clk_in) disable iff (reset_in)
			result_valid[i] |-> !pending[i]);
	end

endmodule

`default_nettype wire

/* logic/osf_param_latch.sv */
`timescale 1ns/100ps
`default_nettype none

// frontpanel parameter registers, one set per channel
module osf_param_latch
	import osf_pkg::*;
#(
	parameter int N_CH = N_CH_DEF,	// channels
	parameter int W_OS = W_OS_DEF	// log2 ratio width
)(
	input  wire                    clk_in,
	input  wire                    reset_in,

	// frontpanel side
	input  wire [w_chan(N_CH):0]   chan_sel_in,	// one spare bit, so bad selects exist
	input  wire [W_OS-1:0]         os_in,
	input  wire [W_DELAY-1:0]      cycle_delay_in,
	input  wire                    update_en_in,	// arms update_in
	input  wire                    update_in,	// single-cycle pulse

	// per channel, to the filters
	output logic [W_OS-1:0]        os_cur [N_CH],
	output logic [W_DELAY-1:0]     cycle_delay [N_CH]
);

	localparam int W_SEL = w_chan(N_CH) + 1;

	logic in_range;	// select names a real channel
	logic load;	// qualified update this cycle

	assign in_range = (chan_sel_in < W_SEL'(N_CH));
	assign load     = update_en_in & update_in & in_range;

	////////////////////////////////////////
	// register bank
	////////////////////////////////////////
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			for (int ch = 0; ch < N_CH; ch++) begin
				os_cur[ch]      <= '0;	// ratio 1
				cycle_delay[ch] <= '0;	// no settling
			end
		end else if (load) begin
			// only the addressed channel moves
			for (int ch = 0; ch < N_CH; ch++) begin
				if (chan_sel_in == W_SEL'(ch)) begin
					os_cur[ch]      <= os_in;
					cycle_delay[ch] <= cycle_delay_in;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* logic/osf_pkg.sv */
`default_nettype none

package osf_pkg;

	////////////////////////////////////////
	// default sizing, overridden from the top
	////////////////////////////////////////
	localparam int W_IN_DEF  = 18;	// adc word
	localparam int W_OUT_DEF = 18;	// filtered word
	localparam int W_OS_DEF  = 3;	// log2 ratio field
	localparam int N_CH_DEF  = 2;	// channel count

	localparam int W_DELAY = 16;	// settling delay count, in samples

	// filter states
	typedef enum logic [1:0] {
		IDLE   = 2'd0,	// channel off
		DELAY  = 2'd1,	// discarding settling samples
		SAMPLE = 2'd2,	// summing the window
		SEND   = 2'd3	// one cycle, result valid
	} osf_state_t;

	// largest log2 ratio a W_OS field can hold
	function automatic int max_os(input int w_os);
		return (1 << w_os) - 1;
	endfunction

	// channel tag width, never below one bit
	function automatic int w_chan(input int n_ch);
		return (n_ch > 1) ? $clog2(n_ch) : 1;
	endfunction

endpackage

`default_nettype wire

/* logic/osf_top.sv */
`timescale 1ns/100ps
`default_nettype none

// oversampling front end: parameter latch, channel filters, output merge
module osf_top
	import osf_pkg::*;
#(
	parameter int N_CH  = N_CH_DEF,
	parameter int W_IN  = W_IN_DEF,
	parameter int W_OUT = W_OUT_DEF,
	parameter int W_OS  = W_OS_DEF
)(
	input  wire                        clk_in,
	input  wire                        reset_in,

	// adc side, one per channel
	input  wire signed [W_IN-1:0]      data_in [N_CH],
	input  wire [N_CH-1:0]             data_valid_in,
	input  wire [N_CH-1:0]             activate_in,

	// frontpanel
	input  wire [w_chan(N_CH):0]       chan_sel_in,
	input  wire [W_OS-1:0]             os_in,
	input  wire [W_DELAY-1:0]          cycle_delay_in,
	input  wire                        update_en_in,
	input  wire                        update_in,

	// toward clock sync
	output logic signed [W_OUT-1:0]    data_out,
	output logic [w_chan(N_CH)-1:0]    chan_out,
	output logic                       data_valid_out
);

	logic [W_OS-1:0]         os_cur [N_CH];
	logic [W_DELAY-1:0]      cycle_delay [N_CH];
	logic signed [W_OUT-1:0] result [N_CH];
	logic [N_CH-1:0]         result_valid;

	osf_param_latch #(
		.N_CH (N_CH),
		.W_OS (W_OS)
	) u_latch (
		.clk_in         (clk_in),
		.reset_in       (reset_in),
		.chan_sel_in    (chan_sel_in),
		.os_in          (os_in),
		.cycle_delay_in (cycle_delay_in),
		.update_en_in   (update_en_in),
		.update_in      (update_in),
		.os_cur         (os_cur),
		.cycle_delay    (cycle_delay)
	);

	////////////////////////////////////////
	// one filter per channel
	////////////////////////////////////////
	for (genvar ch = 0; ch < N_CH; ch++) begin : g_ch
		oversample_filter #(
			.W_IN  (W_IN),
			.W_OUT (W_OUT),
			.W_OS  (W_OS)
		) u_osf (
			.clk_in        (clk_in),
			.reset_in      (reset_in),
			.data_in       (data_in[ch]),
			.data_valid_in (data_valid_in[ch]),
			.activate_in   (activate_in[ch]),
			.os_cur        (os_cur[ch]),
			.cycle_delay   (cycle_delay[ch]),
			.result        (result[ch]),
			.result_valid  (result_valid[ch])
		);
	end

	osf_output_arbiter #(
		.N_CH  (N_CH),
		.W_OUT (W_OUT)
	) u_arb (
		.clk_in         (clk_in),
		.reset_in       (reset_in),
		.result         (result),
		.result_valid   (result_valid),
		.data_out       (data_out),
		.chan_out       (chan_out),
		.data_valid_out (data_valid_out)
	);

endmodule

`default_nettype wire

/* logic/oversample_filter.sv */
`timescale 1ns/100ps
`default_nettype none

// per-channel oversampler
// settle for cycle_delay samples, sum 2^os samples, emit the floor mean
module oversample_filter
	import osf_pkg::*;
#(
	parameter int W_IN  = W_IN_DEF,
	parameter int W_OUT = W_OUT_DEF,
	parameter int W_OS  = W_OS_DEF
)(
	input  wire                     clk_in,
	input  wire                     reset_in,

	// adc side
	input  wire signed [W_IN-1:0]   data_in,
	input  wire                     data_valid_in,	// any cycle
	input  wire                     activate_in,	// level, low acts as local reset

	// latched frontpanel parameters
	input  wire [W_OS-1:0]          os_cur,
	input  wire [W_DELAY-1:0]       cycle_delay,

	// to the arbiter
	output logic signed [W_OUT-1:0] result,	// held until next SEND
	output logic                    result_valid	// one cycle per window
);

	////////////////////////////////////////
	// sizing
	////////////////////////////////////////
	localparam int MAX_OS = max_os(W_OS);
	// counter covers both the delay and the longest window
	localparam int W_CNT  = (W_DELAY > MAX_OS + 1) ? W_DELAY : MAX_OS + 1;

	osf_state_t state;
	osf_state_t next_state;

	logic [W_CNT-1:0]        cnt;	// valid samples seen in this state
	logic [W_CNT-1:0]        win_len;	// 2^os
	logic [W_CNT-1:0]        delay_len;
	logic                    acc_clear;
	logic                    acc_add;
	logic signed [W_OUT-1:0] mean;
	logic signed [W_OUT-1:0] result_hold;

	assign win_len   = W_CNT'(1) << os_cur;
	assign delay_len = W_CNT'(cycle_delay);

	////////////////////////////////////////
	// fsm
	////////////////////////////////////////
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (activate_in) next_state = DELAY;
			end
			DELAY: begin
				// delay of 0 falls straight through
				if (cnt >= delay_len) next_state = SAMPLE;
			end
			SAMPLE: begin
				// last sample of the window is being taken
				if (data_valid_in && (cnt == win_len - 1'b1)) next_state = SEND;
			end
			SEND: begin
				next_state = DELAY;	// settle again before next window
			end
			default: next_state = IDLE;
		endcase
		if (!activate_in) next_state = IDLE;	// deactivation wins from any state
	end

	// sample counter, restarts on each state change
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			cnt <= '0;
		end else if (state != next_state) begin
			cnt <= '0;
		end else if (data_valid_in) begin
			cnt <= cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// datapath
	////////////////////////////////////////
	// partial sum dropped at once on deactivate
	assign acc_clear = (state == IDLE) || (state == DELAY) || !activate_in;
	assign acc_add   = (state == SAMPLE) && data_valid_in && activate_in;

	osf_accumulator #(
		.W_IN  (W_IN),
		.W_OUT (W_OUT),
		.W_OS  (W_OS)
	) u_acc (
		.clk_in   (clk_in),
		.reset_in (reset_in),
		.clear    (acc_clear),
		.add      (acc_add),
		.sample   (data_in),
		.os_cur   (os_cur),
		.mean     (mean)
	);

	assign result_valid = (state == SEND);

	// sum gets cleared in DELAY, so keep a copy of the last mean
	always_ff @(posedge clk_in) begin
		if (result_valid) result_hold <= mean;
	end

	assign result = result_valid ? mean : result_hold;

	////////////////////////////////////////
	// checks
	////////////////////////////////////////
	a_valid_single: assert property (@(posedge clk_in) disable iff (reset_in)
		result_valid |=> !result_valid);

	// frontpanel may only retune an inactive channel
	a_param_stable: assert property (@(posedge clk_in) disable iff (reset_in)
		activate_in |=> (!activate_in || ($stable(os_cur) && $stable(cycle_delay))));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the oversampling front end testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module osf_tb -f build.f -o osf_sim \
	&& ./obj_dir/osf_sim > sim.log 2>&1 \
	|| echo "build or simulation error" >> sim.log

cat sim.log

# any fail line decides, a missing pass line means the run died early
grep -q "sim failed" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "sim passed" sim.log && echo "RESULT: PASS" || { echo "RESULT: FAIL (no pass line)"; exit 1; }

/* test/osf_checker.sv */
`timescale 1ns/100ps
`default_nettype none

// scoreboard: models each channel from its inputs, compares the tagged stream
module osf_checker
	import osf_pkg::*;
#(
	parameter int N_CH  = N_CH_DEF,
	parameter int W_IN  = W_IN_DEF,
	parameter int W_OUT = W_OUT_DEF,
	parameter int W_OS  = W_OS_DEF
)(
	input  wire                    clk_in,
	input  wire                    reset_in,
	input  wire signed [W_IN-1:0]  data_in [N_CH],
	input  wire [N_CH-1:0]         data_valid_in,
	input  wire [N_CH-1:0]         activate_in,
	input  wire [w_chan(N_CH):0]   chan_sel_in,
	input  wire [W_OS-1:0]         os_in,
	input  wire [W_DELAY-1:0]      cycle_delay_in,
	input  wire                    update_en_in,
	input  wire                    update_in,
	input  wire signed [W_OUT-1:0] data_out,
	input  wire [w_chan(N_CH)-1:0] chan_out,
	input  wire                    data_valid_out,
	input  wire                    boundary,	// test end, all queues should be empty
	output int                     err_cnt,
	output int                     results_seen,
	output int                     outstanding
);

	localparam int W_CH = w_chan(N_CH);

	osf_state_t       mode [N_CH];	// modelled filter state
	int               delay_left [N_CH];	// settling samples still to drop
	int               p_os [N_CH];	// modelled parameter latch
	int               p_delay [N_CH];
	longint           win_q [N_CH][$];	// samples of the open window
	logic [W_OUT-1:0] exp_q [N_CH][$];	// expected means, oldest first
	int               errs = 0;
	int               seen = 0;

	// floor of the window mean, division rounded toward minus infinity
	function automatic longint floor_mean(input longint s [$], input int os);
		longint total;
		longint div;
		longint q;
		total = 0;
		foreach (s[i]) total += s[i];
		div = longint'(1) << os;
		q   = total / div;	// truncates toward zero
		if ((total % div != 0) && (total < 0)) q = q - 1;
		return q;
	endfunction

	always @(posedge clk_in) begin : model
		logic [W_OUT-1:0] want;
		int               c;
		int               pend;
		////////////////////////////////////////
		// output side
		////////////////////////////////////////
		if (!reset_in && data_valid_out) begin
			seen++;
			c = int'(chan_out);
			if (exp_q[c].size() == 0) begin
				errs++;
				// another channel waiting means the tag is wrong
				if (exp_q[N_CH-1-c].size() != 0)
					$display("ERR chan_out got %h exp %h", chan_out, W_CH'(N_CH-1-c));
				else
					$display("result on channel %0d arrived with nothing expected", c);
			end else begin
				want = exp_q[c].pop_front();
				if (data_out !== want) begin
					errs++;
					$display("ERR data_out ch%0d got %h exp %h", c, data_out, want);
				end
			end
		end

		////////////////////////////////////////
		// channel models
		////////////////////////////////////////
		if (reset_in) begin
			for (int ch = 0; ch < N_CH; ch++) begin
				mode[ch]    = IDLE;
				p_os[ch]    = 0;
				p_delay[ch] = 0;
				win_q[ch].delete();
				exp_q[ch].delete();
			end
		end else begin
			for (int ch = 0; ch < N_CH; ch++) begin
				if (!activate_in[ch]) begin
					mode[ch] = IDLE;	// partial window lost
					win_q[ch].delete();
				end else begin
					case (mode[ch])
						IDLE, SEND: begin
							mode[ch]       = DELAY;
							delay_left[ch] = p_delay[ch];
						end
						DELAY: begin
							if (delay_left[ch] == 0) mode[ch] = SAMPLE;
							else if (data_valid_in[ch]) delay_left[ch]--;
						end
						SAMPLE: begin
							if (data_valid_in[ch]) begin
								win_q[ch].push_back(longint'(data_in[ch]));
								if (win_q[ch].size() == (1 << p_os[ch])) begin
									exp_q[ch].push_back(W_OUT'(floor_mean(win_q[ch], p_os[ch])));
									win_q[ch].delete();
									mode[ch] = SEND;
								end
							end
						end
						default: mode[ch] = IDLE;
					endcase
				end
			end
			// qualified update, in range only
			if (update_en_in && update_in && (int'(chan_sel_in) < N_CH)) begin
				p_os[int'(chan_sel_in)]    = int'(os_in);
				p_delay[int'(chan_sel_in)] = int'(cycle_delay_in);
			end
		end

		if (boundary) begin
			for (int ch = 0; ch < N_CH; ch++) begin
				if (exp_q[ch].size() != 0) begin
					$display("%0d expected result(s) on channel %0d never arrived",
						exp_q[ch].size(), ch);
					errs += exp_q[ch].size();
					exp_q[ch].delete();
				end
			end
		end

		pend = 0;
		for (int ch = 0; ch < N_CH; ch++) pend += exp_q[ch].size();
		err_cnt      <= errs;
		results_seen <= seen;
		outstanding  <= pend;
	end

endmodule

`default_nettype wire

/* test/osf_tb.sv */
`timescale 1ns/100ps
`default_nettype none

// oversampling front end testbench, stimulus and test sequence
module osf_tb;

	localparam int N_CH  = 2;
	localparam int W_IN  = 18;
	localparam int W_OUT = 18;
	localparam int W_OS  = 3;

	logic                    clk_in;
	logic                    reset_in;
	logic signed [W_IN-1:0]  data_in [N_CH];
	logic [N_CH-1:0]         data_valid_in;
	logic [N_CH-1:0]         activate_in;
	logic [1:0]              chan_sel_in;	// spare bit reaches channels 2 and 3
	logic [W_OS-1:0]         os_in;
	logic [15:0]             cycle_delay_in;
	logic                    update_en_in;
	logic                    update_in;
	logic signed [W_OUT-1:0] data_out;
	logic [0:0]              chan_out;
	logic                    data_valid_out;

	logic        boundary;
	int          err_cnt;
	int          results_seen;
	int          outstanding;	// expected results not yet out
	logic [31:0] lfsr_state;
	int          tb_errs;
	int          tests_run;
	int          tests_failed;

	always #10 clk_in = ~clk_in;	// 20 ns

	osf_top #(.N_CH(N_CH), .W_IN(W_IN), .W_OUT(W_OUT), .W_OS(W_OS)) DUT (
		.clk_in(clk_in), .reset_in(reset_in),
		.data_in(data_in), .data_valid_in(data_valid_in), .activate_in(activate_in),
		.chan_sel_in(chan_sel_in), .os_in(os_in), .cycle_delay_in(cycle_delay_in),
		.update_en_in(update_en_in), .update_in(update_in),
		.data_out(data_out), .chan_out(chan_out), .data_valid_out(data_valid_out)
	);

	osf_checker #(.N_CH(N_CH), .W_IN(W_IN), .W_OUT(W_OUT), .W_OS(W_OS)) u_chk (
		.clk_in(clk_in), .reset_in(reset_in),
		.data_in(data_in), .data_valid_in(data_valid_in), .activate_in(activate_in),
		.chan_sel_in(chan_sel_in), .os_in(os_in), .cycle_delay_in(cycle_delay_in),
		.update_en_in(update_en_in), .update_in(update_in),
		.data_out(data_out), .chan_out(chan_out), .data_valid_out(data_valid_out),
		.boundary(boundary), .err_cnt(err_cnt), .results_seen(results_seen),
		.outstanding(outstanding)
	);

	////////////////////////////////////////
	// random source
	////////////////////////////////////////
	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);	// one step per bit
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	////////////////////////////////////////
	// drivers
	////////////////////////////////////////
	task automatic load_params(input int ch, input int os, input int dly, input bit en);
		@(posedge clk_in);
		chan_sel_in    <= 2'(ch);
		os_in          <= W_OS'(os);
		cycle_delay_in <= 16'(dly);
		update_en_in   <= en;
		update_in      <= 1'b1;	// single pulse
		@(posedge clk_in);
		update_in      <= 1'b0;
		update_en_in   <= 1'b0;
	endtask

	// gap 0 gives random valids, otherwise one valid every gap cycles
	task automatic feed(input logic [N_CH-1:0] chans, input int cycles, input int gap,
		output int sent);
		logic [31:0] r;
		logic        v;
		sent = 0;
		for (int c = 0; c < cycles; c++) begin
			@(posedge clk_in);
			for (int ch = 0; ch < N_CH; ch++) begin
				if (gap > 0) begin
					v = ((c % gap) == gap - 1);
				end else begin
					rand_bits(2, r);
					v = (r[1:0] != 2'b00);	// about 3 in 4
				end
				rand_bits(W_IN, r);
				data_in[ch]       <= r[W_IN-1:0];
				data_valid_in[ch] <= v && chans[ch];
				if (v && chans[ch]) sent++;
			end
		end
		@(posedge clk_in);
		data_valid_in <= '0;
	endtask

	task automatic set_active(input logic [N_CH-1:0] mask);
		@(posedge clk_in);
		activate_in <= mask;
	endtask

	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		repeat (2) @(posedge clk_in);
		while ((outstanding != 0) && (n < limit)) begin
			@(posedge clk_in);
			n++;
		end
		if (outstanding != 0) begin
			$display("timeout after %0d cycles waiting for %0d result(s)", limit, outstanding);
			tb_errs++;
		end
	endtask

	task automatic close_test(input int num, input string name, input int base);
		int errs;
		wait_drain(400);
		@(posedge clk_in);
		boundary <= 1'b1;	// checker flags anything left over
		@(posedge clk_in);
		boundary <= 1'b0;
		repeat (2) @(posedge clk_in);
		errs = err_cnt + tb_errs - base;
		tests_run++;
		if (errs == 0) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: FAILED with %0d error(s)", num, name, errs);
		end
	endtask

	task automatic expect_count(input int got, input int want, input bit at_least);
		if (at_least ? (got < want) : (got != want)) begin
			$display("result count is %0d, wanted %s%0d", got, at_least ? "at least " : "", want);
			tb_errs++;
		end
	endtask

	////////////////////////////////////////
	// sequence
	////////////////////////////////////////
	initial begin
		int base;
		int seen0;
		int sent;
		clk_in         = 1'b0;
		reset_in       = 1'b1;
		data_in[0]     = '0;
		data_in[1]     = '0;
		data_valid_in  = '0;
		activate_in    = '0;
		chan_sel_in    = '0;
		os_in          = '0;
		cycle_delay_in = '0;
		update_en_in   = 1'b0;
		update_in      = 1'b0;
		boundary       = 1'b0;
		lfsr_state     = 32'h57cc0e06;
		tb_errs        = 0;
		tests_run      = 0;
		tests_failed   = 0;
		repeat (10) @(posedge clk_in);
		reset_in <= 1'b0;

		// 1: nothing active, valids must not leak
		base  = err_cnt + tb_errs;
		seen0 = results_seen;
		feed(2'b11, 40, 0, sent);
		repeat (4) @(posedge clk_in);
		expect_count(results_seen - seen0, 0, 1'b0);
		close_test(1, "inactive channels silent", base);

		// 2: os 0 delay 0 passthrough on ch0
		base  = err_cnt + tb_errs;
		seen0 = results_seen;
		load_params(0, 0, 0, 1'b1);
		set_active(2'b01);
		feed(2'b01, 40, 4, sent);
		set_active(2'b00);
		wait_drain(100);
		expect_count(results_seen - seen0, sent, 1'b0);
		close_test(2, "ch0 passthrough", base);

		// 3: ch1 eight sample mean after five settling samples
		base  = err_cnt + tb_errs;
		seen0 = results_seen;
		load_params(1, 3, 5, 1'b1);
		set_active(2'b10);
		feed(2'b10, 240, 0, sent);
		set_active(2'b00);
		wait_drain(100);
		expect_count(results_seen - seen0, 10, 1'b1);
		close_test(3, "ch1 os 3 delay 5", base);

		// 4: both channels, different ratios
		base  = err_cnt + tb_errs;
		seen0 = results_seen;
		load_params(0, 2, 1, 1'b1);
		load_params(1, 1, 3, 1'b1);
		set_active(2'b11);
		feed(2'b11, 240, 0, sent);
		set_active(2'b00);
		wait_drain(100);
		expect_count(results_seen - seen0, 10, 1'b1);
		close_test(4, "two channels tagged", base);

		// 5: disabled and out of range updates leave params alone
		base  = err_cnt + tb_errs;
		seen0 = results_seen;
		load_params(0, 1, 0, 1'b1);
		load_params(1, 2, 2, 1'b1);
		load_params(1, 0, 7, 1'b0);	// enable low
		load_params(2, 0, 0, 1'b1);	// no channel 2
		load_params(3, 5, 9, 1'b1);
		set_active(2'b11);
		feed(2'b11, 150, 0, sent);
		set_active(2'b00);
		wait_drain(100);
		expect_count(results_seen - seen0, 5, 1'b1);
		close_test(5, "ignored updates", base);

		// 6: drop mid window, then reactivate
		base  = err_cnt + tb_errs;
		seen0 = results_seen;
		load_params(1, 3, 2, 1'b1);
		set_active(2'b10);
		feed(2'b10, 20, 1, sent);	// one full window, then 5 of 8
		set_active(2'b00);
		wait_drain(100);
		expect_count(results_seen - seen0, 1, 1'b0);
		set_active(2'b10);
		feed(2'b10, 20, 1, sent);
		set_active(2'b00);
		wait_drain(100);
		expect_count(results_seen - seen0, 2, 1'b0);
		close_test(6, "deactivate mid window", base);

		$display("tests run %0d, failed %0d, errors %0d, results checked %0d",
			tests_run, tests_failed, err_cnt + tb_errs, results_seen);
		if ((tests_failed == 0) && (err_cnt + tb_errs == 0)) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
